/* src/conv_geom_pkg.sv */
// Fixed geometry for one 32x32 frame and a 5x5 kernel; the counters elsewhere are sized for it
`default_nettype none

package conv_geom_pkg;

    // Input frame, one pixel per column, rows arrive top to bottom
    localparam int FRAME_W = 32;
    localparam int FRAME_H = 32;

    localparam int KERNEL = 5; // Window edge, square

    // Valid output positions only, no padding at the borders
    localparam int OUT_W = FRAME_W - KERNEL + 1;
    localparam int OUT_H = FRAME_H - KERNEL + 1;

    // One spare line so the next row can load while a window row is read
    localparam int NUM_LINES = KERNEL + 1;

    localparam int PIXEL_W = 8; // Signed pixel

endpackage

`default_nettype wire

/* src/pixel_types_pkg.sv */
// Pixel and window types for the 5x5 window generator; widths follow conv_geom_pkg and are not free
`default_nettype none

package pixel_types_pkg;

    import conv_geom_pkg::*;

    typedef logic signed [PIXEL_W-1:0] pixel_t;

    // Column index into one line buffer
    typedef logic [$clog2(FRAME_W)-1:0] col_t;

    typedef logic [$clog2(NUM_LINES)-1:0] line_idx_t; // Position in the line ring

    // Row count, must reach FRAME_H itself
    typedef logic [$clog2(FRAME_H+1)-1:0] row_cnt_t;

    // One row slice of a window, tap 0 is the leftmost column
    typedef pixel_t [KERNEL-1:0] taps_t;

    // Full window, row 0 is the topmost frame row
    typedef struct packed {
        taps_t [KERNEL-1:0] row;
    } window_t;

endpackage

`default_nettype wire

/* src/line_write_ctrl.sv */
// Line ring writer; the source must hold i_pixel_valid low while o_line_free is low, else pixels are lost
`default_nettype none

module line_write_ctrl (
    input  wire                                  clk,
    input  wire                                  reset_n,
    input  wire                                  i_start,
    input  wire                                  i_pixel_valid,
    input  wire  pixel_types_pkg::pixel_t        i_pixel,
    input  wire  pixel_types_pkg::row_cnt_t      i_rows_done,
    output logic [conv_geom_pkg::NUM_LINES-1:0]  o_line_we,
    output pixel_types_pkg::col_t                o_wr_col,
    output pixel_types_pkg::pixel_t              o_wr_pixel,
    output pixel_types_pkg::row_cnt_t            o_rows_written,
    output logic                                 o_line_free
);

    import conv_geom_pkg::*;
    import pixel_types_pkg::*;

    localparam col_t      LAST_COL  = col_t'(FRAME_W - 1);
    localparam line_idx_t LAST_LINE = line_idx_t'(NUM_LINES - 1);

    logic      active;       // Frame in progress, until the reader has finished every row
    col_t      wr_col;
    line_idx_t wr_ptr;       // Ring line receiving the current row
    row_cnt_t  rows_written;
    row_cnt_t  lines_used;   // Rows held but not yet released by the reader
    logic      accept;

    assign lines_used  = rows_written - i_rows_done;
    assign o_line_free = active && (rows_written < row_cnt_t'(FRAME_H))
                         && (lines_used < row_cnt_t'(NUM_LINES));
    assign accept      = i_pixel_valid && o_line_free;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            active       <= 1'b0;
            wr_col       <= '0;
            wr_ptr       <= '0;
            rows_written <= '0;
        end else if (i_start && !active) begin
            active       <= 1'b1; // New frame, ring starts at line 0
            wr_col       <= '0;
            wr_ptr       <= '0;
            rows_written <= '0;
        end else begin
            // Reader done with the last row, whole design goes idle
            if (active && i_rows_done == row_cnt_t'(OUT_H)) begin
                active <= 1'b0;
            end
            if (accept) begin
                if (wr_col == LAST_COL) begin
                    wr_col       <= '0;
                    wr_ptr       <= (wr_ptr == LAST_LINE) ? '0 : wr_ptr + 1'b1;
                    rows_written <= rows_written + 1'b1; // Row complete and readable
                end else begin
                    wr_col <= wr_col + 1'b1;
                end
            end
        end
    end

    // One-hot enable, only the current ring line is written
    always_comb begin
        o_line_we = '0;
        if (accept) begin
            o_line_we[wr_ptr] = 1'b1;
        end
    end

    assign o_wr_col       = wr_col;
    assign o_wr_pixel     = i_pixel;
    assign o_rows_written = rows_written;

endmodule

`default_nettype wire

/* src/line_store.sv */
// One frame row of pixels; taps are combinational and i_rd_col must stay at or below OUT_W-1
`default_nettype none

module line_store (
    input  wire                         clk,
    input  wire                         i_we,
    input  wire  pixel_types_pkg::col_t   i_wr_col,
    input  wire  pixel_types_pkg::pixel_t i_wr_pixel,
    input  wire  pixel_types_pkg::col_t   i_rd_col,
    output pixel_types_pkg::taps_t        o_taps
);

    import conv_geom_pkg::*;
    import pixel_types_pkg::*;

    pixel_t mem [FRAME_W]; // Contents undefined until the row is written

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wr_col] <= i_wr_pixel;
        end
    end

    // Five adjacent pixels from the read column, no wrap needed
    always_comb begin
        for (int k = 0; k < KERNEL; k++) begin
            o_taps[k] = mem[i_rd_col + col_t'(k)];
        end
    end

endmodule

`default_nettype wire

/* src/window_reader.sv */
// Raster-order 5x5 window issue; waits on rows written and i_conv_ready, each window valid for one cycle
`default_nettype none

module window_reader (
    input  wire                                                   clk,
    input  wire                                                   reset_n,
    input  wire                                                   i_start,
    input  wire  pixel_types_pkg::row_cnt_t                       i_rows_written,
    input  wire                                                   i_conv_ready,
    input  wire  pixel_types_pkg::taps_t [conv_geom_pkg::NUM_LINES-1:0] i_line_taps,
    output pixel_types_pkg::col_t                                 o_rd_col,
    output pixel_types_pkg::row_cnt_t                             o_rows_done,
    output logic                                                  o_conv_valid,
    output pixel_types_pkg::window_t                              o_window,
    output logic                                                  o_conv_row_start,
    output logic                                                  o_conv_row_end,
    output logic                                                  o_done
);

    import conv_geom_pkg::*;
    import pixel_types_pkg::*;

    localparam col_t      LAST_COL  = col_t'(OUT_W - 1);
    localparam row_cnt_t  LAST_ROW  = row_cnt_t'(OUT_H - 1);
    localparam line_idx_t LAST_LINE = line_idx_t'(NUM_LINES - 1);
    localparam int        IDX_W     = $bits(line_idx_t) + 1; // Room for base plus offset

    typedef logic [IDX_W-1:0] idx_sum_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EMIT,
        ST_FINISH
    } state_t;

    state_t    state;
    row_cnt_t  out_row;  // Current output row, equals the rows finished
    col_t      rd_col;
    line_idx_t base;     // Ring line holding the top window row
    logic      avail;
    logic      fire;
    window_t   win_next;

    // Bottom window row must be fully written
    assign avail = i_rows_written >= out_row + row_cnt_t'(KERNEL);
    assign fire  = (state == ST_EMIT) && i_conv_ready && avail;

    // Pick five ring lines in order starting at the base
    always_comb begin
        idx_sum_t sum;
        for (int i = 0; i < KERNEL; i++) begin
            sum = {1'b0, base} + idx_sum_t'(i);
            if (sum >= idx_sum_t'(NUM_LINES)) begin
                sum = sum - idx_sum_t'(NUM_LINES); // Wrap around the ring
            end
            win_next.row[i] = i_line_taps[sum[IDX_W-2:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state            <= ST_IDLE;
            out_row          <= '0;
            rd_col           <= '0;
            base             <= '0;
            o_conv_valid     <= 1'b0;
            o_conv_row_start <= 1'b0;
            o_conv_row_end   <= 1'b0;
            o_done           <= 1'b0;
        end else begin
            o_conv_valid     <= fire;
            o_conv_row_start <= fire && (rd_col == '0);
            o_conv_row_end   <= fire && (rd_col == LAST_COL);
            o_done           <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        out_row <= '0;
                        rd_col  <= '0;
                        base    <= '0;
                        state   <= ST_EMIT;
                    end
                end
                ST_EMIT: begin
                    if (fire) begin
                        if (rd_col == LAST_COL) begin
                            rd_col  <= '0;
                            out_row <= out_row + 1'b1; // Releases the oldest line to the writer
                            base    <= (base == LAST_LINE) ? '0 : base + 1'b1;
                            if (out_row == LAST_ROW) begin
                                state <= ST_FINISH;
                            end
                        end else begin
                            rd_col <= rd_col + 1'b1;
                        end
                    end
                end
                ST_FINISH: begin
                    o_done <= 1'b1; // Lands one cycle after the last valid
                    state  <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Window payload, held until the next issue
    always_ff @(posedge clk) begin
        if (fire) begin
            o_window <= win_next;
        end
    end

    assign o_rd_col    = rd_col;
    assign o_rows_done = out_row;

endmodule

`default_nettype wire

/* src/window_gen_top.sv */
// 5x5 window generator top; one frame per i_start, pixels only while o_line_free is high
`default_nettype none

module window_gen_top (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         i_start,
    input  wire                         i_pixel_valid,
    input  wire  pixel_types_pkg::pixel_t i_pixel,
    input  wire                         i_conv_ready,
    output logic                        o_line_free,
    output logic                        o_conv_valid,
    output pixel_types_pkg::window_t    o_window,
    output logic                        o_conv_row_start,
    output logic                        o_conv_row_end,
    output logic                        o_done
);

    import conv_geom_pkg::*;
    import pixel_types_pkg::*;

    logic [NUM_LINES-1:0]  line_we;
    col_t                  wr_col;
    pixel_t                wr_pixel;
    col_t                  rd_col;
    row_cnt_t              rows_written;
    row_cnt_t              rows_done;
    taps_t [NUM_LINES-1:0] line_taps;  // Tap slices from every ring line

    line_write_ctrl writer0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_start        (i_start),
        .i_pixel_valid  (i_pixel_valid),
        .i_pixel        (i_pixel),
        .i_rows_done    (rows_done),
        .o_line_we      (line_we),
        .o_wr_col       (wr_col),
        .o_wr_pixel     (wr_pixel),
        .o_rows_written (rows_written),
        .o_line_free    (o_line_free)
    );

    // Line n holds frame rows n, n+6, n+12 and so on
    for (genvar n = 0; n < NUM_LINES; n++) begin : g_line
        line_store line0 (
            .clk        (clk),
            .i_we       (line_we[n]),
            .i_wr_col   (wr_col),
            .i_wr_pixel (wr_pixel),
            .i_rd_col   (rd_col),
            .o_taps     (line_taps[n])
        );
    end

    window_reader reader0 (
        .clk              (clk),
        .reset_n          (reset_n),
        .i_start          (i_start),
        .i_rows_written   (rows_written),
        .i_conv_ready     (i_conv_ready),
        .i_line_taps      (line_taps),
        .o_rd_col         (rd_col),
        .o_rows_done      (rows_done),
        .o_conv_valid     (o_conv_valid),
        .o_window         (o_window),
        .o_conv_row_start (o_conv_row_start),
        .o_conv_row_end   (o_conv_row_end),
        .o_done           (o_done)
    );

endmodule

`default_nettype wire

/* verification/window_gen_properties.sv */
// Bound into window_gen_top; reset checks start from the second reset cycle, before that outputs are unset
`default_nettype none

module window_gen_properties (
    input wire                           clk,
    input wire                           reset_n,
    input wire                           i_pixel_valid,
    input wire                           i_line_free,
    input wire                           i_conv_valid,
    input wire pixel_types_pkg::window_t i_window,
    input wire                           i_row_start,
    input wire                           i_row_end,
    input wire                           i_done
);

    import pixel_types_pkg::*;

    // Registers cleared by the first reset edge
    quiet_in_reset_a : assert property (@(posedge clk)
        (!reset_n && !$past(reset_n)) |->
            !(i_conv_valid || i_row_start || i_row_end || i_done || i_line_free))
        else $error("Output active while reset is held");

    strobe_with_valid_a : assert property (@(posedge clk) disable iff (!reset_n)
        (i_row_start || i_row_end) |-> i_conv_valid)
        else $error("Row strobe without a valid window");

    done_apart_a : assert property (@(posedge clk) disable iff (!reset_n)
        i_done |-> !i_conv_valid)
        else $error("Done pulse together with a valid window");

    pixel_with_room_a : assert property (@(posedge clk) disable iff (!reset_n)
        i_pixel_valid |-> i_line_free)
        else $error("Pixel presented while no line is free");

    window_known_a : assert property (@(posedge clk) disable iff (!reset_n)
        i_conv_valid |-> !$isunknown(i_window))
        else $error("Valid window holds unknown bits");

endmodule

bind window_gen_top window_gen_properties props0 (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_pixel_valid (i_pixel_valid),
    .i_line_free   (o_line_free),
    .i_conv_valid  (o_conv_valid),
    .i_window      (o_window),
    .i_row_start   (o_conv_row_start),
    .i_row_end     (o_conv_row_end),
    .i_done        (o_done)
);

`default_nettype wire

/* verification/window_gen_tb.sv */
// Three random frames through window_gen_top; sources pixels only while the line ring has room
`default_nettype none

module window_gen_tb;

    import conv_geom_pkg::*;
    import pixel_types_pkg::*;

    localparam int          PIXELS      = FRAME_W * FRAME_H;
    localparam int          WINDOWS     = OUT_W * OUT_H;
    localparam logic [31:0] SEED        = 32'h2055_340a;
    localparam int          IDLE_CYCLES = 8;  // Quiet time after done, catches extra pulses
    // Three frames of 1024 pixels and 784 windows, doubled for gaps, with margin
    localparam int          TIMEOUT_CYCLES = 20000;

    logic    clk;
    logic    reset_n;
    logic    i_start;
    logic    i_pixel_valid;
    pixel_t  i_pixel;
    logic    i_conv_ready;
    logic    o_line_free;
    logic    o_conv_valid;
    window_t o_window;
    logic    o_conv_row_start;
    logic    o_conv_row_end;
    logic    o_done;

    pixel_t frame [FRAME_H][FRAME_W]; // Pixels of the frame in flight
    string  test_name;

    // Owned by the compare process
    int      exp_r;
    int      exp_c;
    int      win_count;
    int      row_start_count;
    int      row_end_count;
    int      done_count;
    int      mon_errors;
    int      pix_seen;      // Pixels taken by the writer so far
    logic    frame_active;  // Set by the first start
    logic    free_exp;
    logic    ready_last;
    logic    valid_last;
    window_t exp_win;

    int seq_errors;
    int tests_run;
    int tests_failed;
    int cycle_count;

    window_gen_top dut0 (
        .clk              (clk),
        .reset_n          (reset_n),
        .i_start          (i_start),
        .i_pixel_valid    (i_pixel_valid),
        .i_pixel          (i_pixel),
        .i_conv_ready     (i_conv_ready),
        .o_line_free      (o_line_free),
        .o_conv_valid     (o_conv_valid),
        .o_window         (o_window),
        .o_conv_row_start (o_conv_row_start),
        .o_conv_row_end   (o_conv_row_end),
        .o_done           (o_done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles, in test %s",
                     cycle_count, test_name);
            $display("** FAIL **");
            $finish;
        end
    end

    // Element (i, j) is frame pixel (r+i, c+j)
    function automatic window_t expected_window(input int r, input int c);
        window_t w;
        for (int i = 0; i < KERNEL; i++) begin
            for (int j = 0; j < KERNEL; j++) begin
                w.row[i][j] = frame[r + i][c + j];
            end
        end
        return w;
    endfunction

    task automatic fill_frame();
        for (int r = 0; r < FRAME_H; r++) begin
            for (int c = 0; c < FRAME_W; c++) begin
                frame[r][c] = pixel_t'($urandom_range(255));
            end
        end
    endtask

    // Compare process, samples at the falling edge
    always @(negedge clk) begin
        if (i_start) begin
            exp_r           = 0; // New frame, raster order restarts
            exp_c           = 0;
            win_count       = 0;
            row_start_count = 0;
            row_end_count   = 0;
            done_count      = 0;
            pix_seen        = 0;
            frame_active    = 1'b1;
        end else if (reset_n) begin
            if (o_conv_valid) begin
                assert (ready_last) else begin
                    $display("Test %s: window issued after a cycle with i_conv_ready low",
                             test_name);
                    mon_errors = mon_errors + 1;
                end
                assert (win_count < WINDOWS) else begin
                    $display("Test %s: window issued after the last window of the frame",
                             test_name);
                    mon_errors = mon_errors + 1;
                end
                if (win_count < WINDOWS) begin
                    exp_win = expected_window(exp_r, exp_c);
                    assert (o_window == exp_win) else begin
                        $display("ERROR %s window (%0d,%0d): expected %h actual %h",
                                 test_name, exp_r, exp_c, exp_win, o_window);
                        mon_errors = mon_errors + 1;
                    end
                    assert (o_conv_row_start == (exp_c == 0)) else begin
                        $display("ERROR %s row start at (%0d,%0d): expected %0d actual %0d",
                                 test_name, exp_r, exp_c, (exp_c == 0), o_conv_row_start);
                        mon_errors = mon_errors + 1;
                    end
                    assert (o_conv_row_end == (exp_c == OUT_W - 1)) else begin
                        $display("ERROR %s row end at (%0d,%0d): expected %0d actual %0d",
                                 test_name, exp_r, exp_c, (exp_c == OUT_W - 1), o_conv_row_end);
                        mon_errors = mon_errors + 1;
                    end
                    if (exp_c == OUT_W - 1) begin
                        exp_c = 0;
                        exp_r = exp_r + 1;
                    end else begin
                        exp_c = exp_c + 1;
                    end
                end
                win_count = win_count + 1;
            end
            if (o_conv_row_start) row_start_count = row_start_count + 1;
            if (o_conv_row_end) row_end_count = row_end_count + 1;
            if (o_done) begin
                done_count = done_count + 1;
                assert (win_count == WINDOWS) else begin
                    $display("ERROR %s windows before done: expected %0d actual %0d",
                             test_name, WINDOWS, win_count);
                    mon_errors = mon_errors + 1;
                end
                assert (valid_last) else begin
                    $display("Test %s: done pulse not on the cycle after the last window",
                             test_name);
                    mon_errors = mon_errors + 1;
                end
            end
            // Rows finished include a row end shown in this cycle
            free_exp = frame_active && (pix_seen / FRAME_W < FRAME_H)
                       && (pix_seen / FRAME_W - row_end_count < NUM_LINES);
            assert (o_line_free == free_exp) else begin
                $display("ERROR %s line free after %0d pixels: expected %0d actual %0d",
                         test_name, pix_seen, free_exp, o_line_free);
                mon_errors = mon_errors + 1;
            end
            if (i_pixel_valid && o_line_free) pix_seen = pix_seen + 1;
        end
        ready_last = i_conv_ready; // Ready seen by the reader in the next cycle
        valid_last = o_conv_valid;
    end

    task automatic check_count(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("ERROR %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            seq_errors = seq_errors + 1;
        end
    endtask

    task automatic run_frame(input string name, input int gap_pct, input int stall_pct);
        int   pix_idx;
        int   rows_in;
        int   errs_before;
        int   seq_before;
        int   fails;
        logic room;
        logic send;
        pix_idx     = 0;
        test_name   = name;
        errs_before = mon_errors;
        seq_before  = seq_errors;
        fill_frame();
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        while (done_count == 0) begin
            @(posedge clk);
            rows_in = pix_idx / FRAME_W;
            // Finished rows seen here lag the DUT by at most one, never optimistic
            room = (pix_idx < PIXELS) && (rows_in - row_end_count < NUM_LINES);
            send = room && ($urandom_range(99) >= gap_pct);
            i_pixel_valid <= send;
            if (send) begin
                i_pixel <= frame[rows_in][pix_idx % FRAME_W];
                pix_idx = pix_idx + 1;
            end
            i_conv_ready <= ($urandom_range(99) >= stall_pct);
        end
        i_pixel_valid <= 1'b0;
        i_conv_ready  <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);
        check_count("pixels sent", PIXELS, pix_idx);
        check_count("window count", WINDOWS, win_count);
        check_count("row start pulses", OUT_H, row_start_count);
        check_count("row end pulses", OUT_H, row_end_count);
        check_count("done pulses", 1, done_count);
        fails     = (mon_errors - errs_before) + (seq_errors - seq_before);
        tests_run = tests_run + 1;
        if (fails != 0) tests_failed = tests_failed + 1;
        $display("Test %s: %0d windows, %0d row starts, %0d row ends, %0d done, %0d errors: %s",
                 name, win_count, row_start_count, row_end_count, done_count, fails,
                 (fails == 0) ? "ok" : "failed");
    endtask

    initial begin
        clk           = 1'b0;
        reset_n       = 1'b0;
        i_start       = 1'b0;
        i_pixel_valid = 1'b0;
        i_pixel       = '0;
        i_conv_ready  = 1'b0;
        frame_active  = 1'b0;
        test_name     = "reset";
        void'($urandom(SEED));
        repeat (10) @(posedge clk);
        reset_n      <= 1'b1;
        i_conv_ready <= 1'b1;
        @(posedge clk);
        run_frame("full_frame", 0, 0);
        run_frame("backpressure", 0, 50);
        run_frame("pixel_gaps", 50, 50);
        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d failed checks",
                 tests_run, tests_run - tests_failed, tests_failed, mon_errors + seq_errors);
        if (tests_failed == 0 && mon_errors == 0 && seq_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
src/conv_geom_pkg.sv
src/pixel_types_pkg.sv
src/line_write_ctrl.sv
src/line_store.sv
src/window_reader.sv
src/window_gen_top.sv
verification/window_gen_properties.sv
verification/window_gen_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the window generator testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module window_gen_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vwindow_gen_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
    echo "Result: simulation passed"
    exit 0
else
    echo "Result: simulation failed"
    exit 1
fi
